/* fp_mul.f */
common/fp_mul_pkg.sv
src/fp_mul_booth.sv
src/fp_mul_norm.sv
src/fp_mul_round.sv
src/fp_mul_exp.sv
src/fp_mul_checker.sv
src/fp_mul.sv
dv/fp_mul_tb.sv

/* Bender.yml */
package:
  name: fp_mul

sources:
  - files:
      - common/fp_mul_pkg.sv
      - src/fp_mul_booth.sv
      - src/fp_mul_norm.sv
      - src/fp_mul_round.sv
      - src/fp_mul_exp.sv
      - src/fp_mul_checker.sv
      - src/fp_mul.sv
  - target: test
    files:
      - dv/fp_mul_tb.sv

/* dv/fp_mul_tb.sv */
module fp_mul_tb;
    import fp_mul_pkg::*;

    // Expected result word and flags of one pair
    typedef struct packed {
        fp32_t      z;
        exc_flags_t f;
    } result_t;

    localparam int RST_CYCLES = 16;
    localparam int N_DIRECTED = 15;
    localparam int N_CARRY    = 10;
    localparam int N_PER_MODE = 20;
    localparam int N_VEC      = N_DIRECTED + N_CARRY + 5 * N_PER_MODE;
    // Run length bound in clock cycles
    localparam int LIMIT      = 2 * N_VEC + RST_CYCLES;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    fp32_t       fp_x;
    fp32_t       fp_y;
    round_mode_e r_mode;
    logic        out_valid;
    fp32_t       fp_z;
    exc_flags_t  flags;

    logic [31:0] lfsr     = 32'h443d_f26f;
    int          errors   = 0;
    int          n_issued = 0;
    int          n_seen   = 0;
    int          cycles   = 0;
    logic        started  = 1'b0;
    string       cur_name = "idle";
    string       rec_name = "none";
    string       chk_name = "none";
    result_t     rec      = '0;

    fp_mul uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .fp_x      (fp_x),
        .fp_y      (fp_y),
        .r_mode    (r_mode),
        .out_valid (out_valid),
        .fp_z      (fp_z),
        .flags     (flags)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic fp32_t mk_fp(logic s, logic [7:0] e, logic [22:0] f);
        return '{sign: s, exp: e, frac: f};
    endfunction

    // Exponent kept within 64..191 so most products stay in range
    function automatic fp32_t rand_normal();
        fp32_t r;
        r.sign = 1'(take_bits(1));
        r.exp  = 8'd64 + 8'(take_bits(7));
        r.frac = 23'(take_bits(23));
        return r;
    endfunction

    // Expected result from the multiply rules
    function automatic result_t ref_mul(fp32_t x, fp32_t y, round_mode_e m);
        logic [47:0] prod;
        logic [47:0] sh;
        logic [22:0] mant;
        logic [23:0] mant_r;
        logic        guard;
        logic        rnd;
        logic        sticky;
        logic        inexact;
        logic        up;
        logic        sgn;
        logic        x_z;
        logic        y_z;
        logic        x_i;
        logic        y_i;
        logic        x_n;
        logic        y_n;
        logic        fin;
        logic [9:0]  sum;
        logic [9:0]  bias;
        result_t     r;
        x_z = (x.exp == 8'd0);
        y_z = (y.exp == 8'd0);
        x_i = (x.exp == 8'hff) && (x.frac == '0);
        y_i = (y.exp == 8'hff) && (y.frac == '0);
        x_n = (x.exp == 8'hff) && (x.frac != '0);
        y_n = (y.exp == 8'hff) && (y.frac != '0);
        fin = !x_z && !y_z && (x.exp != 8'hff) && (y.exp != 8'hff);
        sgn = x.sign ^ y.sign;
        // Exact significand product, hidden bit from a nonzero exponent
        prod = {24'd0, !x_z, x.frac} * {24'd0, !y_z, y.frac};
        sh = prod[47] ? prod : (prod << 1);
        mant = sh[46:24];
        guard = sh[23];
        rnd = sh[22];
        sticky = |sh[21:0];
        inexact = guard | rnd | sticky;
        case (m)
            rm_rne:  up = guard & (rnd | sticky | mant[0]);
            rm_rtz:  up = 1'b0;
            rm_rdn:  up = sgn & inexact;
            rm_rup:  up = ~sgn & inexact;
            rm_rmm:  up = guard;
            default: up = 1'b0;
        endcase
        mant_r = {1'b0, mant} + 24'(up);
        sum = 10'(x.exp) + 10'(y.exp);
        // One less bias when the point moved up by one place
        bias = (prod[47] || mant_r[23]) ? 10'd126 : 10'd127;
        r.f.ovrf = fin && (sum >= bias + 10'd255);
        r.f.udrf = fin && (sum <= bias);
        r.f.nan = x_n || y_n || (x_i && y_z) || (y_i && x_z);
        r.f.inf = !r.f.nan && (x_i || y_i || r.f.ovrf);
        r.f.zer = !r.f.nan && !r.f.inf && (x_z || y_z || r.f.udrf);
        if (r.f.nan) begin
            r.z = 32'h7fc0_0000;
        end else if (r.f.inf) begin
            r.z = mk_fp(sgn, 8'hff, '0);
        end else if (r.f.zer) begin
            r.z = mk_fp(sgn, 8'h00, '0);
        end else begin
            r.z = mk_fp(sgn, 8'(sum - bias), mant_r[22:0]);
        end
        return r;
    endfunction

    // One-entry record of the pair the DUT took at this edge
    always @(posedge clk) begin
        if (rst_n && in_valid) begin
            rec      <= ref_mul(fp_x, fp_y, r_mode);
            rec_name <= cur_name;
            started  <= 1'b1;
        end
        if (rst_n && out_valid) begin
            n_seen <= n_seen + 1;
        end
    end

    // Name of the pair whose result is compared at the next rising edge
    always @(negedge clk) begin
        chk_name = rec_name;
    end

    a_result_z: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> fp_z == rec.z)
    else begin
        errors++;
        $display("CHECK FAILED %s fp_z: expected %h actual %h",
            chk_name, $sampled(rec.z), $sampled(fp_z));
    end

    a_result_flags: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> flags == rec.f)
    else begin
        errors++;
        $display("CHECK FAILED %s flags: expected %b actual %b",
            chk_name, $sampled(rec.f), $sampled(flags));
    end

    a_valid_missing: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |=> out_valid)
    else begin
        errors++;
        $display("out_valid did not follow an input strobe one cycle later");
    end

    a_valid_extra: assert property (@(posedge clk) disable iff (!rst_n)
        !in_valid |=> !out_valid)
    else begin
        errors++;
        $display("out_valid went high with no input strobe the cycle before");
    end

    // Output stage stays clear until the first strobe
    a_idle_clear: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> !out_valid && (flags == '0) && (fp_z == '0))
    else begin
        errors++;
        $display("Outputs not clear after reset before the first input strobe");
    end

    // Drive one pair, with an idle cycle after it when gap is set
    task automatic issue(fp32_t x, fp32_t y, round_mode_e m, string name, bit gap);
        @(posedge clk);
        in_valid <= 1'b1;
        fp_x     <= x;
        fp_y     <= y;
        r_mode   <= m;
        cur_name <= name;
        n_issued++;
        if (gap) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    // Special operands, flush to zero, identity and range limits
    task automatic run_directed();
        issue(mk_fp(1'b1, 8'd0, '0), rand_normal(), rm_rne, "zero_x", 1'b1);
        issue(rand_normal(), mk_fp(1'b0, 8'd0, '0), rm_rne, "zero_y", 1'b1);
        issue(mk_fp(1'b0, 8'd0, 23'h12345), mk_fp(1'b1, 8'd130, 23'h1), rm_rup, "subn", 1'b1);
        issue(rand_normal(), 32'h3f80_0000, rm_rne, "one_y", 1'b1);
        issue(32'h3f80_0000, mk_fp(1'b1, 8'd140, 23'h2aaaa), rm_rdn, "one_x", 1'b1);
        issue(32'h7fc0_1234, 32'h4000_0000, rm_rne, "nan_x", 1'b1);
        issue(32'h3f80_0000, 32'hffc0_0001, rm_rtz, "nan_y", 1'b1);
        issue(32'h7f80_0000, 32'h8000_0000, rm_rne, "inf_zero", 1'b1);
        issue(32'h0000_0000, 32'hff80_0000, rm_rne, "zero_inf", 1'b1);
        issue(32'hff80_0000, 32'h4040_0000, rm_rne, "inf_fin", 1'b1);
        issue(32'h7f80_0000, 32'h7f80_0000, rm_rmm, "inf_inf", 1'b1);
        issue(mk_fp(1'b0, 8'd250, 23'(take_bits(23))), mk_fp(1'b1, 8'd250, '0),
            rm_rne, "ovrf", 1'b1);
        issue(mk_fp(1'b1, 8'd10, 23'(take_bits(23))), mk_fp(1'b1, 8'd10, '0),
            rm_rne, "udrf", 1'b1);
        issue(mk_fp(1'b0, 8'd254, '1), 32'h4000_0000, rm_rtz, "ovrf_edge", 1'b1);
        issue(mk_fp(1'b1, 8'd64, '0), mk_fp(1'b0, 8'd63, '0), rm_rne, "udrf_edge", 1'b1);
    endtask

    // Significands 2351*4513 and 13264529 multiply to 2^47 - 1
    // Mantissa all ones with guard and sticky set, so rounding up carries into the exponent
    task automatic run_carry();
        for (int m = 0; m < 5; m++) begin
            for (int s = 0; s < 2; s++) begin
                issue(mk_fp(1'(s), 8'd127, 23'h21e58f), mk_fp(1'b0, 8'd127, 23'h4a6691),
                    round_mode_e'(m), "carry", 1'b0);
            end
        end
    endtask

    // Back-to-back random normal pairs in each mode
    task automatic run_random();
        for (int m = 0; m < 5; m++) begin
            for (int i = 0; i < N_PER_MODE; i++) begin
                issue(rand_normal(), rand_normal(), round_mode_e'(m), "random", 1'b0);
            end
        end
    endtask

    initial begin
        in_valid = 1'b0;
        fp_x     = '0;
        fp_y     = '0;
        r_mode   = rm_rne;
        rst_n    = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        // A few idle cycles to watch the cleared outputs
        repeat (3) @(posedge clk);
        run_directed();
        run_carry();
        run_random();
        @(posedge clk);
        in_valid <= 1'b0;
        while (n_seen != n_issued) @(posedge clk);
        @(posedge clk);
        $display("Errors: %0d, results seen: %0d of %0d", errors, n_seen, n_issued);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog on the total cycle count
    initial begin
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        errors++;
        $display("Timeout after %0d cycles, %0d of %0d results seen", cycles, n_seen, n_issued);
        $display("Errors: %0d, results seen: %0d of %0d", errors, n_seen, n_issued);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* src/fp_mul.sv */
module fp_mul (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  fp_mul_pkg::fp32_t       fp_x,
    input  fp_mul_pkg::fp32_t       fp_y,
    input  fp_mul_pkg::round_mode_e r_mode,
    output logic                    out_valid,
    output fp_mul_pkg::fp32_t       fp_z,
    output fp_mul_pkg::exc_flags_t  flags
);
    import fp_mul_pkg::*;

    logic              hid_x;
    logic              hid_y;
    logic              sign_z;
    logic              norm_n;
    logic              norm_r;
    logic [PROD_W-1:0] frc_z_full;
    logic [FRAC_W+3:0] frc_z_norm;
    logic [FRAC_W-1:0] frc_z;
    logic [7:0]        exp_z;
    exc_flags_t        flags_next;
    fp32_t             fp_z_next;

    // Hidden bit set for a nonzero exponent
    assign hid_x = |fp_x.exp;
    assign hid_y = |fp_y.exp;

    // Product sign
    assign sign_z = fp_x.sign ^ fp_y.sign;

    fp_mul_booth u_booth (
        .frc_x      (fp_x.frac),
        .frc_y      (fp_y.frac),
        .hid_x      (hid_x),
        .hid_y      (hid_y),
        .frc_z_full (frc_z_full)
    );

    fp_mul_norm u_norm (
        .frc_z_full (frc_z_full),
        .frc_z_norm (frc_z_norm),
        .norm_n     (norm_n)
    );

    fp_mul_round u_round (
        .frc_z_norm (frc_z_norm),
        .r_mode     (r_mode),
        .sign_z     (sign_z),
        .frc_z      (frc_z),
        .norm_r     (norm_r)
    );

    fp_mul_exp u_exp (
        .fp_x      (fp_x),
        .fp_y      (fp_y),
        .norm_n    (norm_n),
        .norm_r    (norm_r),
        .sign_z    (sign_z),
        .frc_z     (frc_z),
        .exp_z     (exp_z),
        .flags     (flags_next),
        .fp_z_next (fp_z_next)
    );

    fp_mul_checker u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .fp_x       (fp_x),
        .fp_y       (fp_y),
        .r_mode     (r_mode),
        .frc_z_full (frc_z_full),
        .frc_z_norm (frc_z_norm),
        .norm_n     (norm_n),
        .sign_z     (sign_z),
        .frc_z      (frc_z),
        .norm_r     (norm_r),
        .exp_z      (exp_z),
        .flags      (flags_next),
        .fp_z_next  (fp_z_next)
    );

    // Output stage, loads only on an input strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            fp_z      <= '0;
            flags     <= '0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                fp_z  <= fp_z_next;
                flags <= flags_next;
            end
        end
    end

endmodule

/* src/fp_mul_checker.sv */
module fp_mul_checker (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  fp_mul_pkg::fp32_t             fp_x,
    input  fp_mul_pkg::fp32_t             fp_y,
    input  fp_mul_pkg::round_mode_e       r_mode,
    input  logic [fp_mul_pkg::PROD_W-1:0] frc_z_full,
    input  logic [fp_mul_pkg::FRAC_W+3:0] frc_z_norm,
    input  logic                          norm_n,
    input  logic                          sign_z,
    input  logic [fp_mul_pkg::FRAC_W-1:0] frc_z,
    input  logic                          norm_r,
    input  logic [7:0]                    exp_z,
    input  fp_mul_pkg::exc_flags_t        flags,
    input  fp_mul_pkg::fp32_t             fp_z_next
);
    import fp_mul_pkg::*;

    // 1.0 in single precision
    localparam logic [31:0] FP_ONE = 32'h3f80_0000;

    logic              x_sub;
    logic              y_sub;
    logic              x_nif;
    logic              y_nif;
    logic              x_inf;
    logic              y_inf;
    logic              x_nan;
    logic              y_nan;
    logic              both_norm;
    logic [PROD_W-1:0] prod_ref;
    logic [PROD_W-1:0] norm_ref;
    logic [FRAC_W-1:0] mant;
    logic [FRAC_W:0]   mant_up;
    logic              guard;
    logic              rest;
    logic              inexact;
    logic [9:0]        exp_sum;
    logic [9:0]        bias;
    fp32_t             z_pack;

    // Reference values rebuilt from the operands and the stage nets
    always_comb begin
        x_sub     = (fp_x.exp == '0);
        y_sub     = (fp_y.exp == '0);
        // Exponent all ones, infinity or NaN
        x_nif     = (fp_x.exp == EXP_MAX);
        y_nif     = (fp_y.exp == EXP_MAX);
        x_inf     = x_nif && (fp_x.frac == '0);
        y_inf     = y_nif && (fp_y.frac == '0);
        x_nan     = x_nif && (fp_x.frac != '0);
        y_nan     = y_nif && (fp_y.frac != '0);
        both_norm = !(x_sub || y_sub || x_nif || y_nif);
        // Hidden bit follows a nonzero exponent
        prod_ref  = PROD_W'({!x_sub, fp_x.frac}) * PROD_W'({!y_sub, fp_y.frac});
        norm_ref  = frc_z_full[PROD_W-1] ? frc_z_full : (frc_z_full << 1);
        mant      = frc_z_norm[FRAC_W+2:3];
        mant_up   = {1'b0, mant} + (FRAC_W + 1)'(1);
        guard     = frc_z_norm[2];
        rest      = |frc_z_norm[1:0];
        inexact   = guard || rest;
        exp_sum   = {2'b00, fp_x.exp} + {2'b00, fp_y.exp};
        bias      = (norm_n || norm_r) ? 10'd126 : {2'b00, EXP_BIAS};
        z_pack    = '{sign: sign_z, exp: exp_z, frac: frc_z};
    end

    default clocking cb @(posedge clk);
    endclocking

    default disable iff (!rst_n);

    // Stimulus contract on the mode code
    m_mode_legal: assume property (
        in_valid |-> r_mode inside {rm_rne, rm_rtz, rm_rdn, rm_rup, rm_rmm});

    // Zero or subnormal times a finite value flushes to signed zero
    a_flush_zero: assert property (in_valid && ((x_sub && !y_nif) || (y_sub && !x_nif))
        |-> fp_z_next == {sign_z, 31'b0});

    // Identity under 1.0 on either side
    a_one_y: assert property (in_valid && both_norm && (fp_y == FP_ONE) |-> fp_z_next == fp_x);
    a_one_x: assert property (in_valid && both_norm && (fp_x == FP_ONE) |-> fp_z_next == fp_y);

    // Booth product
    a_booth: assert property (in_valid |-> frc_z_full == prod_ref);

    // Shift, kept bits and sticky
    a_norm_shift: assert property (in_valid |->
        (frc_z_norm == {norm_ref[PROD_W-1 -: FRAC_W+3], |norm_ref[PROD_W-FRAC_W-4:0]}) &&
        (norm_n == frc_z_full[PROD_W-1]));

    // Leading one for two normal operands
    a_norm_lead: assert property (in_valid && both_norm |-> frc_z_norm[FRAC_W+3]);

    a_sign: assert property (in_valid |-> sign_z == (fp_x.sign ^ fp_y.sign));

    // Rounding, one rule per mode
    a_rnd_rne: assert property (in_valid && (r_mode == rm_rne) |->
        frc_z == ((guard && (rest || mant[0])) ? mant_up[FRAC_W-1:0] : mant));
    a_rnd_rtz: assert property (in_valid && (r_mode == rm_rtz) |-> frc_z == mant);
    a_rnd_rdn: assert property (in_valid && (r_mode == rm_rdn) |->
        frc_z == ((sign_z && inexact) ? mant_up[FRAC_W-1:0] : mant));
    a_rnd_rup: assert property (in_valid && (r_mode == rm_rup) |->
        frc_z == ((!sign_z && inexact) ? mant_up[FRAC_W-1:0] : mant));
    a_rnd_rmm: assert property (in_valid && (r_mode == rm_rmm) |->
        frc_z == (guard ? mant_up[FRAC_W-1:0] : mant));

    // Carry only out of an all-ones mantissa, leaving zeros behind
    a_rnd_carry: assert property (in_valid && norm_r |-> mant_up[FRAC_W] && (frc_z == '0));

    // Exponent with the bias picked from the two carries
    a_exp: assert property (in_valid |-> exp_z == 8'(exp_sum - bias));

    // Range flags against the raw exponent sum
    a_udrf: assert property (in_valid && flags.udrf |-> exp_sum <= bias);
    a_ovrf: assert property (in_valid && flags.ovrf |-> exp_sum >= bias + 10'd255);
    a_udrf_set: assert property (in_valid && both_norm && (exp_sum <= bias) |-> flags.udrf);
    a_ovrf_set: assert property (in_valid && both_norm && (exp_sum >= bias + 10'd255)
        |-> flags.ovrf);

    // Exception flag conditions
    a_exc_zer: assert property (in_valid &&
        (flags.udrf || (x_sub && !y_nif) || (y_sub && !x_nif)) |-> flags.zer);
    a_exc_inf: assert property (in_valid && flags.inf |-> x_inf || y_inf || flags.ovrf);
    a_exc_inf_set: assert property (in_valid && !flags.nan && (x_inf || y_inf) |-> flags.inf);
    a_exc_nan: assert property (in_valid |->
        flags.nan == (x_nan || y_nan || (x_inf && y_sub) || (y_inf && x_sub)));

    // Net result per class
    a_net_nan: assert property (in_valid && flags.nan |-> fp_z_next == QNAN);
    a_net_inf: assert property (in_valid && flags.inf |-> fp_z_next == {sign_z, EXP_MAX, 23'b0});
    a_net_zer: assert property (in_valid && flags.zer |-> fp_z_next == {sign_z, 31'b0});
    a_net_z: assert property (in_valid && !flags.nan && !flags.inf && !flags.zer
        |-> fp_z_next == z_pack);

endmodule

/* src/fp_mul_exp.sv */
module fp_mul_exp (
    input  fp_mul_pkg::fp32_t             fp_x,
    input  fp_mul_pkg::fp32_t             fp_y,
    input  logic                          norm_n,
    input  logic                          norm_r,
    input  logic                          sign_z,
    input  logic [fp_mul_pkg::FRAC_W-1:0] frc_z,
    output logic [7:0]                    exp_z,
    output fp_mul_pkg::exc_flags_t        flags,
    output fp_mul_pkg::fp32_t             fp_z_next
);
    import fp_mul_pkg::*;

    logic [9:0] exp_sum;
    logic [9:0] bias;
    logic       x_sub;
    logic       y_sub;
    logic       x_inf;
    logic       y_inf;
    logic       x_nan;
    logic       y_nan;
    logic       both_norm;

    // Operand classes, zero and subnormal share one class
    assign x_sub = (fp_x.exp == '0);
    assign y_sub = (fp_y.exp == '0);
    assign x_inf = (fp_x.exp == EXP_MAX) && (fp_x.frac == '0);
    assign y_inf = (fp_y.exp == EXP_MAX) && (fp_y.frac == '0);
    assign x_nan = (fp_x.exp == EXP_MAX) && (fp_x.frac != '0);
    assign y_nan = (fp_y.exp == EXP_MAX) && (fp_y.frac != '0);

    // Both operands normal and finite
    assign both_norm = !(x_sub || y_sub || (fp_x.exp == EXP_MAX) || (fp_y.exp == EXP_MAX));

    // Ten bits hold the raw sum with room for the range checks
    assign exp_sum = {2'b00, fp_x.exp} + {2'b00, fp_y.exp};

    // One less bias when normalization or rounding moved the point
    assign bias  = {2'b00, EXP_BIAS} - {9'd0, norm_n | norm_r};
    assign exp_z = exp_sum[7:0] - bias[7:0];

    // Flags and result selection, NaN first, then infinity, then zero
    always_comb begin
        flags.nan  = x_nan | y_nan | (x_inf & y_sub) | (y_inf & x_sub);
        // Range flags only for two normal operands
        flags.ovrf = both_norm & (exp_sum >= bias + 10'd255);
        flags.udrf = both_norm & (exp_sum <= bias);
        flags.inf  = !flags.nan & (x_inf | y_inf | flags.ovrf);
        flags.zer  = !flags.nan & !flags.inf & (x_sub | y_sub | flags.udrf);

        if (flags.nan) begin
            fp_z_next = QNAN;
        end else if (flags.inf) begin
            fp_z_next = '{sign: sign_z, exp: EXP_MAX, frac: '0};
        end else if (flags.zer) begin
            fp_z_next = '{sign: sign_z, exp: '0, frac: '0};
        end else begin
            fp_z_next = '{sign: sign_z, exp: exp_z, frac: frc_z};
        end
    end

    // Result class is unique
    a_exp_class: assert final (
        $isunknown(flags) || $onehot0({flags.nan, flags.inf, flags.zer})
    );

endmodule

/* src/fp_mul_round.sv */
module fp_mul_round (
    input  logic [fp_mul_pkg::FRAC_W+3:0] frc_z_norm,
    input  fp_mul_pkg::round_mode_e       r_mode,
    input  logic                          sign_z,
    output logic [fp_mul_pkg::FRAC_W-1:0] frc_z,
    output logic                          norm_r
);
    import fp_mul_pkg::*;

    logic [FRAC_W-1:0] mant;
    logic              guard;
    logic              rest;
    logic              inexact;
    logic              inc;

    // Mantissa without the leading one
    assign mant = frc_z_norm[FRAC_W+2:3];

    // Guard bit, then round and sticky merged
    assign guard = frc_z_norm[2];
    assign rest  = |frc_z_norm[1:0];

    // Any discarded bit set
    assign inexact = guard | rest;

    // Increment decision per mode
    always_comb begin
        case (r_mode)
            // Above half, or exactly half with an odd mantissa
            rm_rne:  inc = guard & (rest | mant[0]);
            // Truncate
            rm_rtz:  inc = 1'b0;
            // Magnitude grows only for negative results
            rm_rdn:  inc = sign_z & inexact;
            // Magnitude grows only for positive results
            rm_rup:  inc = ~sign_z & inexact;
            // Half or more rounds away from zero
            rm_rmm:  inc = guard;
            default: inc = 1'b0;
        endcase
    end

    // All-ones mantissa plus one carries into the exponent
    assign {norm_r, frc_z} = {1'b0, mant} + (FRAC_W + 1)'(inc);

    // Only the five defined mode codes reach this block
    a_round_mode: assert final (
        $isunknown(r_mode) || (r_mode inside {rm_rne, rm_rtz, rm_rdn, rm_rup, rm_rmm})
    );

endmodule

/* src/fp_mul_norm.sv */
module fp_mul_norm (
    input  logic [fp_mul_pkg::PROD_W-1:0] frc_z_full,
    output logic [fp_mul_pkg::FRAC_W+3:0] frc_z_norm,
    output logic                          norm_n
);
    import fp_mul_pkg::*;

    logic [PROD_W-1:0] shifted;
    logic              sticky;

    // Product in [2,4) already has its leading one at bit 47
    assign norm_n = frc_z_full[PROD_W-1];

    // Product in [1,2) moves up one place
    assign shifted = norm_n ? frc_z_full : {frc_z_full[PROD_W-2:0], 1'b0};

    // Everything below the round bit collapses into sticky
    assign sticky = |shifted[PROD_W-FRAC_W-4:0];

    // Leading one, 23 mantissa bits, guard, round, sticky
    assign frc_z_norm = {shifted[PROD_W-1 -: FRAC_W+3], sticky};

    // Two hidden bits give a product of at least 2^46
    // The shift must then leave the leading one at the top
    a_norm_lead: assert final (
        $isunknown(frc_z_full) || (frc_z_full[PROD_W-1:PROD_W-2] == 2'b00) ||
        frc_z_norm[FRAC_W+3]
    );

    // Sticky never loses a nonzero product
    a_norm_keep: assert final (
        $isunknown(frc_z_full) || (frc_z_full == '0) || (frc_z_norm != '0)
    );

endmodule

/* src/fp_mul_booth.sv */
module fp_mul_booth (
    input  logic [fp_mul_pkg::FRAC_W-1:0] frc_x,
    input  logic [fp_mul_pkg::FRAC_W-1:0] frc_y,
    input  logic                          hid_x,
    input  logic                          hid_y,
    output logic [fp_mul_pkg::PROD_W-1:0] frc_z_full
);
    import fp_mul_pkg::*;

    // Twelve radix-4 digits span the 24-bit multiplier
    localparam int NDIG = (FRAC_W + 1) / 2;

    logic [FRAC_W:0]   mcand;
    logic [FRAC_W:0]   mplier;
    logic [FRAC_W+1:0] mplier_ext;
    logic [PROD_W-1:0] mcand_w;
    logic [PROD_W-1:0] pp [NDIG];

    // Significands with their hidden bits
    assign mcand  = {hid_x, frc_x};
    assign mplier = {hid_y, frc_y};

    // Implicit zero below the multiplier LSB starts the first digit group
    assign mplier_ext = {mplier, 1'b0};

    // Multiplicand widened to the product width
    assign mcand_w = PROD_W'(mcand);

    // Booth recoding, each group of three bits picks a digit from -2 to +2
    // Negative rows rely on modulo 2^48 wrap for their sign extension
    always_comb begin
        for (int i = 0; i < NDIG; i++) begin
            case (mplier_ext[2*i +: 3])
                // Digit +1
                3'b001, 3'b010: pp[i] = mcand_w << (2 * i);
                // Digit +2
                3'b011:         pp[i] = mcand_w << (2 * i + 1);
                // Digit -2
                3'b100:         pp[i] = -(mcand_w << (2 * i + 1));
                // Digit -1
                3'b101, 3'b110: pp[i] = -(mcand_w << (2 * i));
                // Digit 0
                default:        pp[i] = '0;
            endcase
        end
    end

    // Partial product sum
    // The top digit treats the hidden bit as a sign bit
    // Adding the multiplicand at weight 2^24 restores the unsigned product
    always_comb begin
        frc_z_full = mplier[FRAC_W] ? (mcand_w << (FRAC_W + 1)) : '0;
        for (int i = 0; i < NDIG; i++) begin
            frc_z_full = frc_z_full + pp[i];
        end
    end

    // Recoded sum matches a plain unsigned multiply
    a_booth_exact: assert final (
        $isunknown({mcand, mplier}) || (frc_z_full == mcand_w * PROD_W'(mplier))
    );

endmodule

/* common/fp_mul_pkg.sv */
package fp_mul_pkg;

    // Fraction width of a single precision word
    localparam int FRAC_W = 23;

    // Full product of two 24-bit significands
    localparam int PROD_W = 48;

    // Exponent bias and the all-ones exponent for infinity and NaN
    localparam logic [7:0] EXP_BIAS = 8'd127;
    localparam logic [7:0] EXP_MAX  = 8'd255;

    // Canonical quiet NaN, positive sign, only the quiet bit set
    localparam logic [31:0] QNAN = 32'h7fc0_0000;

    // IEEE-754 single precision word
    typedef struct packed {
        logic              sign;
        logic [7:0]        exp;
        logic [FRAC_W-1:0] frac;
    } fp32_t;

    // Rounding modes, codes 5 to 7 unused
    typedef enum logic [2:0] {
        rm_rne = 3'd0,
        rm_rtz = 3'd1,
        rm_rdn = 3'd2,
        rm_rup = 3'd3,
        rm_rmm = 3'd4
    } round_mode_e;

    // Exception flags of one result
    typedef struct packed {
        // Signed zero result
        logic zer;
        // Signed infinity result
        logic inf;
        // Quiet NaN result
        logic nan;
        // Exponent sum beyond the largest normal
        logic ovrf;
        // Exponent sum below the smallest normal
        logic udrf;
    } exc_flags_t;

endpackage
